// File: design/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;                 // Data and address width
    localparam int IMEM_DEPTH = 64;                 // Instruction words
    localparam int DMEM_DEPTH = 64;                 // Data words
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH); // Instruction word index bits
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH); // Data word index bits
    localparam int REG_AW     = 5;                  // Register index bits

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,                     // add sub and or slt
        OP_I      = 7'b0010011,                     // addi andi ori slti
        OP_LOAD   = 7'b0000011,                     // lw
        OP_STORE  = 7'b0100011,                     // sw
        OP_BRANCH = 7'b1100011,                     // beq bne
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } op_e;

    typedef enum logic [1:0] {
        ALUOP_MEM    = 2'b00,                       // Address add
        ALUOP_BRANCH = 2'b01,                       // Compare by subtract
        ALUOP_ARITH  = 2'b10                        // Decode funct fields
    } alu_op_e;

    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } imm_src_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SUB = 4'b0001,
        ALU_AND = 4'b0010,
        ALU_OR  = 4'b0011,
        ALU_SLT = 4'b0101                           // Signed less than
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,                            // ALU result to rd
        RES_MEM = 2'b01,                            // Load data to rd
        RES_PC4 = 2'b10                             // Link address to rd
    } result_src_e;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } r_view_t;

    typedef struct packed {
        logic [6:0]        imm_hi;                  // imm[11:5]
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_lo;                  // imm[4:0]
        logic [6:0]        opcode;
    } s_view_t;

    typedef union packed {
        r_view_t r_view;                            // R, I and J fields
        s_view_t s_view;                            // S and B fields
    } instr_u;

    typedef struct packed {
        logic              pc_src;                  // Branch or jal target
        result_src_e       result_src;
        logic              mem_write;
        logic              alu_src;                 // Immediate as ALU operand B
        logic              reg_write;
        logic              jalr_pc_src;             // Register based target
        alu_ctrl_e         alu_ctrl;
        logic [XLEN-1:0]   imm_op;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
    } ctrl_t;

    typedef struct packed {
        logic               we;                     // Load strobe
        logic [IMEM_AW-1:0] addr;                   // Word index
        logic [XLEN-1:0]    data;
    } prog_wr_t;

endpackage

// File: design/instr_mem.sv
`timescale 1ns/1ps

module instr_mem (
    input  logic                  clk_i,
    input  rv_pkg::prog_wr_t      prog_i,  // Program load port
    input  logic [rv_pkg::XLEN-1:0] addr_i, // Byte address from PC
    output rv_pkg::instr_u        rd_o     // Fetched instruction
);

    logic [rv_pkg::XLEN-1:0] mem [rv_pkg::IMEM_DEPTH]; // Word array

    always_ff @(posedge clk_i) begin
        if (prog_i.we) begin
            mem[prog_i.addr] <= prog_i.data; // Visible one edge later
        end
    end

    // Fetch drops the byte offset bits
    assign rd_o = mem[addr_i[rv_pkg::IMEM_AW+1:2]];

endmodule

// File: design/main_decoder.sv
`timescale 1ns/1ps

module main_decoder (
    input  logic                eq_i,          // Operands equal
    input  rv_pkg::op_e         op_i,          // Opcode
    input  logic [2:0]          funct3_i,      // Branch sense in bit 0
    output logic                pc_src_o,      // Take PC relative target
    output rv_pkg::result_src_e result_src_o,  // Write-back select
    output logic                mem_write_o,   // Store enable
    output logic                alu_src_o,     // Immediate as operand B
    output rv_pkg::imm_src_e    imm_src_o,     // Immediate format
    output logic                reg_write_o,   // Register write enable
    output logic                jalr_pc_src_o, // Target from rs1 + imm
    output rv_pkg::alu_op_e     alu_op_o       // ALU op class
);

    always_comb begin
        pc_src_o      = 1'b0;                 // Safe defaults, no writes
        result_src_o  = rv_pkg::RES_ALU;
        mem_write_o   = 1'b0;
        alu_src_o     = 1'b0;
        imm_src_o     = rv_pkg::IMM_I;
        reg_write_o   = 1'b0;
        jalr_pc_src_o = 1'b0;
        alu_op_o      = rv_pkg::ALUOP_MEM;
        case (op_i)
            rv_pkg::OP_R: begin
                reg_write_o = 1'b1;
                alu_op_o    = rv_pkg::ALUOP_ARITH;
            end
            rv_pkg::OP_I: begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_op_o    = rv_pkg::ALUOP_ARITH;
            end
            rv_pkg::OP_LOAD: begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;          // rs1 + offset
                result_src_o = rv_pkg::RES_MEM;
            end
            rv_pkg::OP_STORE: begin
                mem_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = rv_pkg::IMM_S;
            end
            rv_pkg::OP_BRANCH: begin
                imm_src_o = rv_pkg::IMM_B;
                alu_op_o  = rv_pkg::ALUOP_BRANCH;
                pc_src_o  = funct3_i[0] ? ~eq_i : eq_i; // bne inverts beq
            end
            rv_pkg::OP_JAL: begin
                reg_write_o  = 1'b1;
                imm_src_o    = rv_pkg::IMM_J;
                result_src_o = rv_pkg::RES_PC4; // Link
                pc_src_o     = 1'b1;          // Always taken
            end
            rv_pkg::OP_JALR: begin
                reg_write_o   = 1'b1;
                alu_src_o     = 1'b1;
                result_src_o  = rv_pkg::RES_PC4;
                jalr_pc_src_o = 1'b1;
            end
            default: ;                        // Unknown opcode acts as nop
        endcase
    end

endmodule

// File: design/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder (
    input  logic [2:0]          funct3_i,      // Operation select
    input  logic                funct7_i,      // funct7 bit 5
    input  logic                op5_i,         // Opcode bit 5, set for R-type
    input  rv_pkg::alu_op_e     alu_op_i,      // Op class from main decoder
    output rv_pkg::alu_ctrl_e   alu_control_o
);

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALUOP_MEM:    alu_control_o = rv_pkg::ALU_ADD; // Address add
            rv_pkg::ALUOP_BRANCH: alu_control_o = rv_pkg::ALU_SUB; // Compare
            default: begin
                case (funct3_i)
                    3'b000: begin
                        if (funct7_i && op5_i) begin
                            alu_control_o = rv_pkg::ALU_SUB;   // R-type sub only
                        end else begin
                            alu_control_o = rv_pkg::ALU_ADD;   // add, addi
                        end
                    end
                    3'b010:  alu_control_o = rv_pkg::ALU_SLT;  // slt, slti
                    3'b110:  alu_control_o = rv_pkg::ALU_OR;   // or, ori
                    3'b111:  alu_control_o = rv_pkg::ALU_AND;  // and, andi
                    default: alu_control_o = rv_pkg::ALU_ADD;  // Outside the subset
                endcase
            end
        endcase
    end

endmodule

// File: design/sign_extend.sv
`timescale 1ns/1ps

module sign_extend (
    input  rv_pkg::instr_u          instr_i,   // Raw instruction
    input  rv_pkg::imm_src_e        imm_src_i, // Immediate format
    output logic [rv_pkg::XLEN-1:0] imm_ext_o  // Sign-extended immediate
);

    logic sign;                                // Instruction bit 31

    assign sign = instr_i.r_view.funct7[6];

    always_comb begin
        case (imm_src_i)
            rv_pkg::IMM_I: imm_ext_o = {{20{sign}},
                                        instr_i.r_view.funct7,
                                        instr_i.r_view.rs2};     // imm[11:0]
            rv_pkg::IMM_S: imm_ext_o = {{20{sign}},
                                        instr_i.s_view.imm_hi,
                                        instr_i.s_view.imm_lo};  // Split store offset
            rv_pkg::IMM_B: imm_ext_o = {{20{sign}},
                                        instr_i.s_view.imm_lo[0],   // imm[11]
                                        instr_i.s_view.imm_hi[5:0], // imm[10:5]
                                        instr_i.s_view.imm_lo[4:1], // imm[4:1]
                                        1'b0};                      // Halfword aligned
            rv_pkg::IMM_J: imm_ext_o = {{12{sign}},
                                        instr_i.r_view.rs1,         // imm[19:15]
                                        instr_i.r_view.funct3,      // imm[14:12]
                                        instr_i.r_view.rs2[0],      // imm[11]
                                        instr_i.r_view.funct7[5:0], // imm[10:5]
                                        instr_i.r_view.rs2[4:1],    // imm[4:1]
                                        1'b0};
            default:       imm_ext_o = '0;
        endcase
    end

endmodule

// File: design/control_top.sv
`timescale 1ns/1ps

module control_top (
    input  logic                    clk_i,
    input  rv_pkg::prog_wr_t        prog_i, // Program load port
    input  logic [rv_pkg::XLEN-1:0] pc_i,   // Current PC
    input  logic                    eq_i,   // rs1 == rs2 from datapath
    output rv_pkg::ctrl_t           ctrl_o  // Decoded control bundle
);

    rv_pkg::instr_u   instr;                // Current instruction
    rv_pkg::alu_op_e  alu_op;               // Op class to ALU decoder
    rv_pkg::imm_src_e imm_src;              // Immediate format

    instr_mem u_instr_mem (
        .clk_i  (clk_i),
        .prog_i (prog_i),
        .addr_i (pc_i),
        .rd_o   (instr)
    );

    main_decoder u_main_decoder (
        .eq_i          (eq_i),
        .op_i          (rv_pkg::op_e'(instr.r_view.opcode)),
        .funct3_i      (instr.r_view.funct3),
        .pc_src_o      (ctrl_o.pc_src),
        .result_src_o  (ctrl_o.result_src),
        .mem_write_o   (ctrl_o.mem_write),
        .alu_src_o     (ctrl_o.alu_src),
        .imm_src_o     (imm_src),
        .reg_write_o   (ctrl_o.reg_write),
        .jalr_pc_src_o (ctrl_o.jalr_pc_src),
        .alu_op_o      (alu_op)
    );

    alu_decoder u_alu_decoder (
        .funct3_i      (instr.r_view.funct3),
        .funct7_i      (instr.r_view.funct7[5]), // sub and sra marker
        .op5_i         (instr.r_view.opcode[5]), // R-type vs I-type
        .alu_op_i      (alu_op),
        .alu_control_o (ctrl_o.alu_ctrl)
    );

    sign_extend u_sign_extend (
        .instr_i   (instr),
        .imm_src_i (imm_src),
        .imm_ext_o (ctrl_o.imm_op)
    );

    assign ctrl_o.rs1 = instr.r_view.rs1;   // Same position in every format
    assign ctrl_o.rs2 = instr.r_view.rs2;
    assign ctrl_o.rd  = instr.r_view.rd;

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                      clk_i,
    input  logic                      rst_i,      // Sync, active high
    input  logic                      we_i,       // Write enable
    input  logic [rv_pkg::REG_AW-1:0] rd_addr_i,  // Write index
    input  logic [rv_pkg::XLEN-1:0]   rd_data_i,  // Write data
    input  logic [rv_pkg::REG_AW-1:0] rs1_addr_i,
    input  logic [rv_pkg::REG_AW-1:0] rs2_addr_i,
    input  logic [rv_pkg::REG_AW-1:0] dbg_addr_i, // Debug read index
    output logic [rv_pkg::XLEN-1:0]   rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]   rs2_data_o,
    output logic [rv_pkg::XLEN-1:0]   dbg_data_o
);

    logic [rv_pkg::XLEN-1:0] regs [32];           // x0..x31

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;                    // Architectural state cleared
            end
        end else if (we_i && (rd_addr_i != '0)) begin
            regs[rd_addr_i] <= rd_data_i;         // x0 writes dropped
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i]; // x0 hardwired
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];
    assign dbg_data_o = (dbg_addr_i == '0) ? '0 : regs[dbg_addr_i]; // Same cycle

endmodule

// File: design/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                    clk_i,
    input  logic                    rst_i,      // Sync, active high
    input  logic                    run_i,      // Retire one instruction per edge
    input  rv_pkg::ctrl_t           ctrl_i,     // Decoded control
    input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
    output logic [rv_pkg::XLEN-1:0] pc_o,       // Fetch address
    output logic                    eq_o,       // Branch compare
    output logic                    rd_we_o,    // Register write strobe
    output logic [rv_pkg::XLEN-1:0] rd_data_o   // Write-back value
);

    logic [rv_pkg::XLEN-1:0] pc;                // Program counter
    logic [rv_pkg::XLEN-1:0] pc_next;
    logic [rv_pkg::XLEN-1:0] pc_plus4;          // Sequential PC and link value
    logic [rv_pkg::XLEN-1:0] pc_target;         // Branch or jal target
    logic [rv_pkg::XLEN-1:0] jalr_target;       // rs1 + imm, bit 0 cleared
    logic [rv_pkg::XLEN-1:0] alu_b;             // Second ALU operand
    logic [rv_pkg::XLEN-1:0] alu_result;
    logic [rv_pkg::XLEN-1:0] read_data;         // Load data
    logic [rv_pkg::XLEN-1:0] dmem [rv_pkg::DMEM_DEPTH]; // Word data memory

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc <= '0;                           // Fetch from word 0
        end else if (run_i) begin
            pc <= pc_next;                      // Holds while halted
        end
    end

    assign pc_plus4    = pc + 32'd4;
    assign pc_target   = pc + ctrl_i.imm_op;
    assign jalr_target = alu_result & ~32'd1;   // ALU adds rs1 and imm for jalr

    always_comb begin
        if (ctrl_i.jalr_pc_src) begin
            pc_next = jalr_target;
        end else if (ctrl_i.pc_src) begin
            pc_next = pc_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    assign alu_b = ctrl_i.alu_src ? ctrl_i.imm_op : rs2_data_i;

    always_comb begin
        case (ctrl_i.alu_ctrl)
            rv_pkg::ALU_ADD: alu_result = rs1_data_i + alu_b;
            rv_pkg::ALU_SUB: alu_result = rs1_data_i - alu_b;
            rv_pkg::ALU_AND: alu_result = rs1_data_i & alu_b;
            rv_pkg::ALU_OR:  alu_result = rs1_data_i | alu_b;
            rv_pkg::ALU_SLT: alu_result = {31'd0, $signed(rs1_data_i) < $signed(alu_b)};
            default:         alu_result = '0;
        endcase
    end

    assign eq_o = (rs1_data_i == rs2_data_i);   // Direct compare, not ALU zero

    always_ff @(posedge clk_i) begin
        if (run_i && ctrl_i.mem_write) begin
            dmem[alu_result[rv_pkg::DMEM_AW+1:2]] <= rs2_data_i; // Word store
        end
    end

    assign read_data = dmem[alu_result[rv_pkg::DMEM_AW+1:2]];    // Async read

    always_comb begin
        case (ctrl_i.result_src)
            rv_pkg::RES_MEM: rd_data_o = read_data;
            rv_pkg::RES_PC4: rd_data_o = pc_plus4; // Link address
            default:         rd_data_o = alu_result;
        endcase
    end

    assign rd_we_o = ctrl_i.reg_write & run_i; // No writes while halted
    assign pc_o    = pc;

endmodule

// File: design/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                      clk_i,
    input  logic                      rst_i,      // Sync, active high
    input  logic                      run_i,      // High to execute
    input  rv_pkg::prog_wr_t          prog_i,     // Program load while halted
    input  logic [rv_pkg::REG_AW-1:0] dbg_addr_i, // Register peek index
    output logic [rv_pkg::XLEN-1:0]   pc_o,
    output logic [rv_pkg::XLEN-1:0]   dbg_data_o
);

    rv_pkg::ctrl_t           ctrl;                // Decoder to datapath
    logic                    eq;                  // Combinational loop back to decoder
    logic                    rd_we;
    logic [rv_pkg::XLEN-1:0] rd_data;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;

    control_top u_control_top (
        .clk_i  (clk_i),
        .prog_i (prog_i),
        .pc_i   (pc_o),
        .eq_i   (eq),
        .ctrl_o (ctrl)
    );

    datapath u_datapath (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .run_i      (run_i),
        .ctrl_i     (ctrl),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .pc_o       (pc_o),
        .eq_o       (eq),
        .rd_we_o    (rd_we),
        .rd_data_o  (rd_data)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .we_i       (rd_we),
        .rd_addr_i  (ctrl.rd),
        .rd_data_i  (rd_data),
        .rs1_addr_i (ctrl.rs1),
        .rs2_addr_i (ctrl.rs2),
        .dbg_addr_i (dbg_addr_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .dbg_data_o (dbg_data_o)
    );

endmodule

// File: bench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam int TRACE_WORDS = 128;               // Header, program and pairs
    localparam int IDLE_CYCLES = 4;                 // Halted cycles for freeze check

    logic                      clk;
    logic                      rst;
    logic                      run;
    rv_pkg::prog_wr_t          prog;                // Program load port
    logic [rv_pkg::REG_AW-1:0] dbg_addr;
    logic [rv_pkg::XLEN-1:0]   pc;
    logic [rv_pkg::XLEN-1:0]   dbg_data;

    logic [31:0] trace [TRACE_WORDS];               // Raw trace words
    logic [31:0] exp_regs [32];                     // Unlisted registers expect 0
    logic [31:0] exp_pc;
    int          pair_reg [$];                      // Registers named in the trace
    int          prog_len;
    int          run_cycles;
    int          pair_cnt;
    int          idx;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000;                // Replaced once the trace is read
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    bit          trace_ok;

    cpu_top dut (
        .clk_i      (clk),
        .rst_i      (rst),
        .run_i      (run),
        .prog_i     (prog),
        .dbg_addr_i (dbg_addr),
        .pc_o       (pc),
        .dbg_data_o (dbg_data)
    );

    always #10 clk = ~clk;                          // 20 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not end within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic next_cycle();                    // 1 ns past the next rising edge
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected %08h, actual %08h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s %0d mismatch(es)", name, test_errors);
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            prog.we   = 1'b1;
            prog.addr = i[rv_pkg::IMEM_AW-1:0];     // Word index
            prog.data = trace[1 + i];
            next_cycle();                           // Write lands on this edge
        end
        prog = '0;
    endtask

    task automatic read_all_regs(input string name, input bit use_trace);
        logic [31:0] expected;
        for (int r = 0; r < 32; r++) begin
            dbg_addr = r[rv_pkg::REG_AW-1:0];
            @(negedge clk);                         // Debug read settled mid cycle
            expected = use_trace ? exp_regs[r] : 32'd0;
            check_value($sformatf("%s x%0d", name, r), expected, dbg_data);
            next_cycle();
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        run          = 1'b0;
        prog         = '0;
        dbg_addr     = '0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        exp_pc       = '0;
        run_cycles   = 0;
        pair_cnt     = 0;
        foreach (trace[i]) trace[i] = '0;           // Missing file reads as length 0
        foreach (exp_regs[i]) exp_regs[i] = '0;
        $readmemh("bench/cpu_trace.txt", trace);
        prog_len = int'(trace[0]);
        trace_ok = (prog_len > 0) && (prog_len <= rv_pkg::IMEM_DEPTH);
        if (trace_ok) begin
            run_cycles = int'(trace[prog_len + 1]);
            exp_pc     = trace[prog_len + 2];
            pair_cnt   = int'(trace[prog_len + 3]);
            trace_ok   = (run_cycles > 0) && (prog_len + 4 + 2 * pair_cnt <= TRACE_WORDS);
        end
        if (trace_ok) begin
            for (int p = 0; p < pair_cnt; p++) begin
                idx = int'(trace[prog_len + 4 + 2 * p]);
                if (idx > 0 && idx < 32) begin      // x0 is never listed
                    exp_regs[idx] = trace[prog_len + 5 + 2 * p];
                    pair_reg.push_back(idx);
                end else begin
                    trace_ok = 1'b0;
                end
            end
        end
        assert (trace_ok) else begin
            $display("Trace file bench/cpu_trace.txt is missing or malformed");
            errors++;
        end
        cycle_limit = prog_len + run_cycles + 64 + 20; // Load, run, reads, margin

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        if (trace_ok) begin
            load_program();
            @(negedge clk);
            check_value("reset_state pc", 32'd0, pc); // Core still halted
            next_cycle();
            read_all_regs("reset_state", 1'b0);
            close_test("reset_state");

            run = 1'b1;
            repeat (run_cycles) next_cycle();       // One retire per edge
            run = 1'b0;
            @(negedge clk);
            check_value("final_pc", exp_pc, pc);
            close_test("final_pc");
            next_cycle();

            read_all_regs("final_regs", 1'b1);      // Halted for all 32 reads
            close_test("final_regs");

            for (int k = 0; k < IDLE_CYCLES; k++) begin
                idx      = (k < pair_reg.size()) ? pair_reg[k] : 0;
                dbg_addr = idx[rv_pkg::REG_AW-1:0];
                @(negedge clk);
                check_value($sformatf("halt_freeze pc cycle %0d", k), exp_pc, pc);
                check_value($sformatf("halt_freeze x%0d", idx), exp_regs[idx], dbg_data);
                next_cycle();
            end
            close_test("halt_freeze");
        end

        $display("tests run %0d, passed %0d, failed %0d, mismatches %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
design/rv_pkg.sv
design/instr_mem.sv
design/main_decoder.sv
design/alu_decoder.sv
design/sign_extend.sv
design/control_top.sv
design/reg_file.sv
design/datapath.sv
design/cpu_top.sv
bench/cpu_tb.sv

// File: bench/cpu_trace.txt
// Program length, program words, run cycles, final PC, pair count,
// then pairs of register index and expected value (all hex)
0000001A
00500093 FFD00113 002081B3 40208233
0020F2B3 0020E333 001123B3 FFF0A413
0060F493 0080E513 00708013 00402423
00802583 00108463 00100613 00109463
00100693 0080076F 00100793 06000813
004808E7 00100993 00100993 00100993
00100993 00700913
00000014
00000068
0000000F
01 00000005  02 FFFFFFFD  03 00000002
04 00000008  05 00000005  06 FFFFFFFD
07 00000001  09 00000004  0A 0000000D
0B 00000008  0D 00000001  0E 00000048
10 00000060  11 00000054  12 00000007
